// ==== source/mmu_pkg.sv ====
//--------------------------------------------------
// Shared widths, enums and structs of the MMU.
// Every module refers to these by scoped name.
//--------------------------------------------------
`default_nettype none

package mmu_pkg;

    //--------------------------------------------------
    // Address widths
    localparam int PAGE_BITS_DEF   = 10;  // Default page number width
    localparam int OFFSET_BITS     = 10;  // Word offset within a page
    localparam int BESM6_PAGE_BITS = 5;   // Page bits used in BESM-6 mode
    localparam int VADDR_BITS      = PAGE_BITS_DEF + OFFSET_BITS;

    //--------------------------------------------------
    // Enums
    typedef enum logic [2:0] {
        OP_SET_MODE    = 3'd0,  // Load no_paging and besm6
        OP_MAP_WRITE   = 3'd1,  // Write a page-map entry
        OP_TRANSLATE   = 3'd2,  // Translate, mark used/dirty
        OP_SET_ACCESS  = 3'd3,  // Direct write of used/dirty
        OP_READ_STATUS = 3'd4,  // Read used/dirty/reprio
        OP_SET_REPRIO  = 3'd5,  // Direct write of reprio
        OP_FILL_REPRIO = 3'd6   // Sweep all reprio bits to 1
    } mmu_op_t;

    // Bus arbiter opcodes, kept as the access kind
    typedef enum logic [3:0] {
        ARB_INSTR_RD  = 4'd1,   // Instruction cache read
        ARB_INSTR_WR  = 4'd2,   // Instruction cache write
        ARB_DATA_RD   = 4'd3,   // Operand cache read
        ARB_DATA_WR   = 4'd4,   // Operand cache write
        ARB_RESULT_WR = 4'd10,  // Result write
        ARB_RMW       = 4'd11,  // Read-modify-write
        ARB_BLOCK_WR  = 4'd12   // Block transfer write
    } arb_kind_t;

    typedef enum logic [1:0] {
        IDLE = 2'd0,  // Nothing executing
        EXEC = 2'd1,  // One command executing
        FILL = 2'd2   // Reprio sweep running
    } ctl_state_t;

    //--------------------------------------------------
    // Command and response
    typedef struct packed {
        mmu_op_t                  op;    // Opcode
        arb_kind_t                kind;  // Access kind of a translate
        logic [VADDR_BITS-1:0]    addr;  // Virtual address, page in upper field
        logic [PAGE_BITS_DEF-1:0] data;  // Map entry, status or mode bits
    } mmu_cmd_t;

    typedef struct packed {
        mmu_op_t                              op;         // Opcode it answers
        logic [PAGE_BITS_DEF+OFFSET_BITS-1:0] phys_addr;  // Translated address
        logic                                 used;       // Page referenced
        logic                                 dirty;      // Page modified
        logic                                 reprio;     // Reprioritize request
    } mmu_rsp_t;

endpackage

`default_nettype wire

// ==== source/cmd_fifo.sv ====
//--------------------------------------------------
// Command FIFO with credit return. The sender owns
// CMD_DEPTH credits, so a write always finds room.
// One credit pulse follows every pop by a cycle.
//--------------------------------------------------
`default_nettype none

module cmd_fifo #(
    parameter int CMD_DEPTH = 4  // Entries, equal to sender credits
) (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    i_valid,       // Write strobe
    input  wire mmu_pkg::mmu_cmd_t i_cmd,
    input  wire                    i_pop,         // Head consumed
    output logic                   o_head_valid,  // FIFO not empty
    output mmu_pkg::mmu_cmd_t      o_head,
    output logic                   o_credit       // Credit back to sender
);

    localparam int PTR_BITS = (CMD_DEPTH > 1) ? $clog2(CMD_DEPTH) : 1;
    localparam int CNT_BITS = $clog2(CMD_DEPTH + 1);

    mmu_pkg::mmu_cmd_t   mem [CMD_DEPTH];  // Entry storage
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;

    assign o_head_valid = (count != '0);
    assign o_head       = mem[rd_ptr];

    // Pointer wrap, depth need not be a power of two
    function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
        if (ptr == PTR_BITS'(CMD_DEPTH - 1))
            return '0;
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (i_valid)
            mem[wr_ptr] <= i_cmd;  // Room guaranteed by credits
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            o_credit <= 1'b0;
        end else begin
            if (i_valid)
                wr_ptr <= next_ptr(wr_ptr);
            if (i_pop)
                rd_ptr <= next_ptr(rd_ptr);
            case ({i_valid, i_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Both or neither
            endcase
            o_credit <= i_pop;  // Slot is free again
        end
    end

endmodule

`default_nettype wire

// ==== source/mmu_control.sv ====
//--------------------------------------------------
// MMU control. Pops the FIFO, holds the executing
// command, decodes it into single-cycle strobes, keeps
// the mode bits and registers the response.
//--------------------------------------------------
`default_nettype none

module mmu_control #(
    parameter int PAGE_BITS = mmu_pkg::PAGE_BITS_DEF  // Page number width
) (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    i_head_valid,
    input  wire mmu_pkg::mmu_cmd_t i_head,
    output logic                   o_pop,         // Take FIFO head
    output mmu_pkg::mmu_cmd_t      o_exec,        // Executing command
    output logic                   o_exec_valid,
    output logic                   o_map_we,      // Page-map write
    output logic                   o_no_paging,   // Mode: translation bypass
    output logic                   o_besm6,       // Mode: narrow page field
    output logic                   o_access_en,   // Translate marks used/dirty
    output logic                   o_set_access,  // Direct used/dirty write
    output logic                   o_set_reprio,  // Direct reprio write
    output logic                   o_read_en,     // Capture status bits
    output logic                   o_fill_start,  // Start reprio sweep
    input  wire                    i_fill_busy,
    input  wire [PAGE_BITS+mmu_pkg::OFFSET_BITS-1:0] i_phys_addr,
    input  wire                    i_used,
    input  wire                    i_dirty,
    input  wire                    i_reprio,
    output logic                   o_rsp_valid,
    output mmu_pkg::mmu_rsp_t      o_rsp
);

    localparam int RSP_ADDR_BITS = mmu_pkg::PAGE_BITS_DEF + mmu_pkg::OFFSET_BITS;

    mmu_pkg::ctl_state_t      state;
    mmu_pkg::ctl_state_t      next_state;
    logic                     fill_hold;  // Sweep still running
    logic                     rsp_cmd;    // Executing op gets a response
    mmu_pkg::mmu_op_t         rsp_op;
    logic [RSP_ADDR_BITS-1:0] rsp_phys;

    //--------------------------------------------------
    // Sequencing
    assign o_exec_valid = (state == mmu_pkg::EXEC);
    assign fill_hold    = (state == mmu_pkg::FILL) && i_fill_busy;
    assign o_pop        = i_head_valid && !o_fill_start && !fill_hold;

    always_comb begin
        if (o_fill_start)
            next_state = mmu_pkg::FILL;
        else if (fill_hold)
            next_state = mmu_pkg::FILL;
        else if (o_pop)
            next_state = mmu_pkg::EXEC;  // Executes at the next edge
        else
            next_state = mmu_pkg::IDLE;
    end

    // Opcode to strobes, each lasts the single exec cycle
    always_comb begin
        o_map_we     = 1'b0;
        o_access_en  = 1'b0;
        o_set_access = 1'b0;
        o_set_reprio = 1'b0;
        o_read_en    = 1'b0;
        o_fill_start = 1'b0;
        rsp_cmd      = 1'b0;
        if (o_exec_valid) begin
            case (o_exec.op)
                mmu_pkg::OP_MAP_WRITE:   o_map_we     = 1'b1;
                mmu_pkg::OP_SET_ACCESS:  o_set_access = 1'b1;
                mmu_pkg::OP_SET_REPRIO:  o_set_reprio = 1'b1;
                mmu_pkg::OP_FILL_REPRIO: o_fill_start = 1'b1;
                mmu_pkg::OP_TRANSLATE: begin
                    o_access_en = 1'b1;
                    rsp_cmd     = 1'b1;
                end
                mmu_pkg::OP_READ_STATUS: begin
                    o_read_en = 1'b1;
                    rsp_cmd   = 1'b1;
                end
                default: ;  // Set-mode handled below
            endcase
        end
    end

    //--------------------------------------------------
    // State, mode register, response strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= mmu_pkg::IDLE;
            o_no_paging <= 1'b0;  // Paging on
            o_besm6     <= 1'b0;  // Native page field
            o_rsp_valid <= 1'b0;
        end else begin
            state <= next_state;
            if (o_exec_valid && o_exec.op == mmu_pkg::OP_SET_MODE) begin
                o_no_paging <= o_exec.data[0];
                o_besm6     <= o_exec.data[1];
            end
            o_rsp_valid <= rsp_cmd;
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        if (o_pop)
            o_exec <= i_head;
        if (rsp_cmd) begin
            rsp_op <= o_exec.op;
            if (o_exec.op == mmu_pkg::OP_TRANSLATE)
                rsp_phys <= RSP_ADDR_BITS'(i_phys_addr);
            else
                rsp_phys <= '0;  // Status reads carry no address
        end
    end

    // Status bits are registered in page_status at the same edge
    always_comb begin
        o_rsp           = '0;
        o_rsp.op        = rsp_op;
        o_rsp.phys_addr = rsp_phys;
        if (rsp_op == mmu_pkg::OP_READ_STATUS) begin
            o_rsp.used   = i_used;
            o_rsp.dirty  = i_dirty;
            o_rsp.reprio = i_reprio;
        end
    end

endmodule

`default_nettype wire

// ==== source/page_map.sv ====
//--------------------------------------------------
// Page-map memory and address translation. Output is
// combinational from the executing command.
//--------------------------------------------------
`default_nettype none

module page_map #(
    parameter int PAGE_BITS = mmu_pkg::PAGE_BITS_DEF  // Page number width
) (
    input  wire                    clk,
    input  wire                    i_we,         // OP_MAP_WRITE strobe
    input  wire mmu_pkg::mmu_cmd_t i_cmd,
    input  wire                    i_no_paging,  // Bypass the map
    input  wire                    i_besm6,      // Low page bits only
    output logic [PAGE_BITS+mmu_pkg::OFFSET_BITS-1:0] o_phys_addr
);

    localparam int OFFSET_BITS = mmu_pkg::OFFSET_BITS;

    logic [PAGE_BITS-1:0]   map_mem [2**PAGE_BITS];  // Physical page per virtual page
    logic [PAGE_BITS-1:0]   page_field;
    logic [OFFSET_BITS-1:0] offset;
    logic [PAGE_BITS-1:0]   virt_page;
    logic [PAGE_BITS-1:0]   phys_page;

    assign page_field = i_cmd.addr[OFFSET_BITS +: PAGE_BITS];
    assign offset     = i_cmd.addr[OFFSET_BITS-1:0];

    always_ff @(posedge clk) begin
        if (i_we)
            map_mem[page_field] <= i_cmd.data[PAGE_BITS-1:0];
    end

    // BESM-6 sees a 5-bit page field
    assign virt_page = i_besm6
        ? PAGE_BITS'(page_field[mmu_pkg::BESM6_PAGE_BITS-1:0])
        : page_field;

    assign phys_page   = i_no_paging ? virt_page : map_mem[virt_page];
    assign o_phys_addr = {phys_page, offset};  // Offset passes unchanged

endmodule

`default_nettype wire

// ==== source/page_status.sv ====
//--------------------------------------------------
// Per-page used, dirty and reprioritize bits. Translate
// accesses mark pages, direct writes and reads go by
// the page field, and a sweep sets every reprio bit.
//--------------------------------------------------
`default_nettype none

module page_status #(
    parameter int PAGE_BITS = mmu_pkg::PAGE_BITS_DEF  // Page number width
) (
    input  wire                    clk,
    input  wire                    reset,
    input  wire mmu_pkg::mmu_cmd_t i_cmd,
    input  wire [PAGE_BITS-1:0]    i_phys_page,   // Translated page
    input  wire                    i_access_en,   // Mark translated page
    input  wire                    i_set_access,  // Write used/dirty
    input  wire                    i_set_reprio,  // Write reprio
    input  wire                    i_read_en,     // Capture all three bits
    input  wire                    i_fill_start,  // Begin sweep at page 0
    output logic                   o_used,
    output logic                   o_dirty,
    output logic                   o_reprio,
    output logic                   o_fill_busy
);

    logic                 used_mem   [2**PAGE_BITS];  // Page referenced
    logic                 dirty_mem  [2**PAGE_BITS];  // Page modified
    logic                 reprio_mem [2**PAGE_BITS];  // Reprioritize request
    logic [PAGE_BITS-1:0] page;
    logic [PAGE_BITS-1:0] fill_cnt;                   // Sweep position
    logic                 dirtying;

    assign page = i_cmd.addr[mmu_pkg::OFFSET_BITS +: PAGE_BITS];

    // Write kinds and read-modify-write modify the page
    always_comb begin
        case (i_cmd.kind)
            mmu_pkg::ARB_INSTR_WR,
            mmu_pkg::ARB_DATA_WR,
            mmu_pkg::ARB_RESULT_WR,
            mmu_pkg::ARB_RMW,
            mmu_pkg::ARB_BLOCK_WR: dirtying = 1'b1;
            default:               dirtying = 1'b0;
        endcase
    end

    //--------------------------------------------------
    // Used and dirty arrays
    always_ff @(posedge clk) begin
        if (i_access_en) begin
            used_mem[i_phys_page] <= 1'b1;
            if (dirtying)
                dirty_mem[i_phys_page] <= 1'b1;
        end else if (i_set_access) begin
            used_mem[page]  <= i_cmd.data[0];
            dirty_mem[page] <= i_cmd.data[1];
        end
    end

    // Reprio array, sweep and single write never overlap
    always_ff @(posedge clk) begin
        if (o_fill_busy)
            reprio_mem[fill_cnt] <= 1'b1;
        else if (i_set_reprio)
            reprio_mem[page] <= i_cmd.data[2];
    end

    always_ff @(posedge clk) begin
        if (i_read_en) begin
            o_used   <= used_mem[page];
            o_dirty  <= dirty_mem[page];
            o_reprio <= reprio_mem[page];
        end
    end

    //--------------------------------------------------
    // Fill sweep counter
    always_ff @(posedge clk) begin
        if (reset) begin
            o_fill_busy <= 1'b0;
            fill_cnt    <= '0;
        end else if (i_fill_start) begin
            o_fill_busy <= 1'b1;
            fill_cnt    <= '0;
        end else if (o_fill_busy) begin
            if (fill_cnt == '1)
                o_fill_busy <= 1'b0;  // Last page written
            fill_cnt <= fill_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== source/mmu_top.sv ====
//--------------------------------------------------
// MMU top level. Commands enter a credited FIFO, the
// control module executes them against the page map
// and the page status arrays, responses leave in order.
//--------------------------------------------------
`default_nettype none

module mmu_top #(
    parameter int PAGE_BITS = mmu_pkg::PAGE_BITS_DEF,  // Page number width
    parameter int CMD_DEPTH = 4                        // FIFO depth, initial credits
) (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  i_cmd_valid,  // Spends one credit
    input  wire mmu_pkg::mmu_cmd_t i_cmd,
    output logic                 o_credit,     // Returns one credit
    output logic                 o_rsp_valid,  // One-cycle response strobe
    output mmu_pkg::mmu_rsp_t    o_rsp
);

    logic                              head_valid;
    mmu_pkg::mmu_cmd_t                 head;
    logic                              pop;
    mmu_pkg::mmu_cmd_t                 exec;
    logic                              map_we;
    logic                              no_paging;
    logic                              besm6;
    logic                              access_en;
    logic                              set_access;
    logic                              set_reprio;
    logic                              read_en;
    logic                              fill_start;
    logic                              fill_busy;
    logic [PAGE_BITS+mmu_pkg::OFFSET_BITS-1:0] phys_addr;
    logic                              used;
    logic                              dirty;
    logic                              reprio;

    cmd_fifo #(.CMD_DEPTH(CMD_DEPTH)) u_fifo (
        .clk(clk), .reset(reset),
        .i_valid(i_cmd_valid), .i_cmd(i_cmd),
        .i_pop(pop), .o_head_valid(head_valid), .o_head(head),
        .o_credit(o_credit)
    );

    mmu_control #(.PAGE_BITS(PAGE_BITS)) u_control (
        .clk(clk), .reset(reset),
        .i_head_valid(head_valid), .i_head(head), .o_pop(pop),
        .o_exec(exec), .o_exec_valid(),
        .o_map_we(map_we), .o_no_paging(no_paging), .o_besm6(besm6),
        .o_access_en(access_en), .o_set_access(set_access),
        .o_set_reprio(set_reprio), .o_read_en(read_en),
        .o_fill_start(fill_start), .i_fill_busy(fill_busy),
        .i_phys_addr(phys_addr),
        .i_used(used), .i_dirty(dirty), .i_reprio(reprio),
        .o_rsp_valid(o_rsp_valid), .o_rsp(o_rsp)
    );

    page_map #(.PAGE_BITS(PAGE_BITS)) u_map (
        .clk(clk), .i_we(map_we), .i_cmd(exec),
        .i_no_paging(no_paging), .i_besm6(besm6),
        .o_phys_addr(phys_addr)
    );

    page_status #(.PAGE_BITS(PAGE_BITS)) u_status (
        .clk(clk), .reset(reset), .i_cmd(exec),
        .i_phys_page(phys_addr[mmu_pkg::OFFSET_BITS +: PAGE_BITS]),
        .i_access_en(access_en), .i_set_access(set_access),
        .i_set_reprio(set_reprio), .i_read_en(read_en),
        .i_fill_start(fill_start),
        .o_used(used), .o_dirty(dirty), .o_reprio(reprio),
        .o_fill_busy(fill_busy)
    );

endmodule

`default_nettype wire

// ==== tests/tb_clock.sv ====
//--------------------------------------------------
// Testbench clock and reset source. Free-running
// clock, reset held high for the first few edges.
//--------------------------------------------------
`default_nettype none

module tb_clock #(
    parameter int HALF_PERIOD  = 10,  // Half of the clock period
    parameter int RESET_CYCLES = 2    // Rising edges with reset high
) (
    output logic o_clk,
    output logic o_reset
);

    initial begin
        o_clk = 1'b0;
        forever #HALF_PERIOD o_clk = ~o_clk;
    end

    initial begin
        o_reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clk);
        o_reset <= 1'b0;  // Released right after an edge
    end

endmodule

`default_nettype wire

// ==== tests/mmu_tb.sv ====
//--------------------------------------------------
// MMU testbench. Replays tests/mmu_stim.txt through a
// credit-counting driver with random idle gaps and
// checks every response in command order.
//--------------------------------------------------
`default_nettype none

module mmu_tb;

    localparam int PAGE_BITS    = 10;
    localparam int CMD_DEPTH    = 4;
    localparam int CLK_PERIOD   = 20;
    localparam int FIELDS       = 9;   // Words per stimulus line
    localparam int MAX_LINES    = 64;
    localparam int DRAIN_CYCLES = 2 ** PAGE_BITS + 4 * CMD_DEPTH;  // Trailing fill included

    logic              clk;
    logic              reset;
    logic              cmd_valid;
    mmu_pkg::mmu_cmd_t cmd;
    logic              credit;
    logic              rsp_valid;
    mmu_pkg::mmu_rsp_t rsp;

    logic [19:0]       stim_mem [0:FIELDS*MAX_LINES-1];  // FIELDS words per stimulus line
    int                line_count   = 0;
    int                fill_count   = 0;
    int                limit_cycles = 0;  // Watchdog budget
    int                sent_cnt     = 0;  // Commands seen by the DUT
    int                returned_cnt = 0;  // Credit pulses seen
    logic [31:0]       rand_state;
    mmu_pkg::mmu_rsp_t exp_q [$];         // Expected responses in command order

    tb_clock #(.HALF_PERIOD(CLK_PERIOD / 2), .RESET_CYCLES(2)) u_clock (
        .o_clk(clk), .o_reset(reset)
    );

    mmu_top #(.PAGE_BITS(PAGE_BITS), .CMD_DEPTH(CMD_DEPTH)) uut (
        .clk(clk), .reset(reset),
        .i_cmd_valid(cmd_valid), .i_cmd(cmd), .o_credit(credit),
        .o_rsp_valid(rsp_valid), .o_rsp(rsp)
    );

    //--------------------------------------------------
    // Helpers
    task automatic end_with_failure();
        $display("*** FAILED ***");
        $fatal(1, "Run stopped at time %0t", $time);
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("FAILED at time %0t: %s is %0h, expected %0h", $time, what, got, want);
            end_with_failure();
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Credits held now including a strobe in flight
    function automatic int free_credits();
        return CMD_DEPTH - sent_cnt - int'(cmd_valid) + returned_cnt;
    endfunction

    //--------------------------------------------------
    // Credit bookkeeping
    always @(posedge clk) begin
        if (!reset) begin
            if (credit)
                returned_cnt <= returned_cnt + 1;
            if (cmd_valid)
                sent_cnt <= sent_cnt + 1;
            if (returned_cnt + int'(credit) > sent_cnt + int'(cmd_valid)) begin
                $display("The credit counter went above %0d at time %0t", CMD_DEPTH, $time);
                end_with_failure();
            end
        end
    end

    // Response checker
    always @(posedge clk) begin : check_rsp
        mmu_pkg::mmu_rsp_t want;
        if (!reset && rsp_valid) begin
            if (exp_q.size() == 0) begin
                $display("A response arrived at time %0t while none was expected", $time);
                end_with_failure();
            end else begin
                want = exp_q.pop_front();
                check_value("op", rsp.op, want.op);
                check_value("phys_addr", rsp.phys_addr, want.phys_addr);
                check_value("used", rsp.used, want.used);
                check_value("dirty", rsp.dirty, want.dirty);
                check_value("reprio", rsp.reprio, want.reprio);
            end
        end
    end

    //--------------------------------------------------
    // Stimulus
    initial begin : drive
        mmu_pkg::mmu_cmd_t next_cmd;
        mmu_pkg::mmu_rsp_t next_rsp;
        int                base;
        int                gap;
        int                wait_cycles;
        cmd_valid  = 1'b0;
        cmd        = '0;
        rand_state = 32'h792;
        $readmemh("tests/mmu_stim.txt", stim_mem);
        while (line_count < MAX_LINES && !$isunknown(stim_mem[line_count * FIELDS])) begin
            if (stim_mem[line_count * FIELDS][2:0] == mmu_pkg::OP_FILL_REPRIO)
                fill_count++;
            line_count++;
        end
        if (line_count == 0) begin
            $display("No stimulus lines could be read from tests/mmu_stim.txt");
            end_with_failure();
        end
        limit_cycles = 40 * line_count + fill_count * (2 ** PAGE_BITS);

        wait (reset == 1'b0);
        @(posedge clk);
        for (int n = 0; n < line_count; n++) begin
            base          = n * FIELDS;
            rand_state    = xorshift32(rand_state);
            gap           = rand_state % 4;  // Idle cycles before this command
            next_cmd.op   = mmu_pkg::mmu_op_t'(stim_mem[base][2:0]);
            next_cmd.kind = mmu_pkg::arb_kind_t'(stim_mem[base + 1][3:0]);
            next_cmd.addr = stim_mem[base + 2];
            next_cmd.data = stim_mem[base + 3][9:0];
            cmd_valid <= 1'b0;
            repeat (gap) @(posedge clk);
            while (free_credits() == 0)
                @(posedge clk);  // FIFO full until a credit returns
            cmd       <= next_cmd;
            cmd_valid <= 1'b1;
            if (stim_mem[base + 4][0]) begin
                next_rsp.op        = next_cmd.op;
                next_rsp.phys_addr = stim_mem[base + 5];
                next_rsp.used      = stim_mem[base + 6][0];
                next_rsp.dirty     = stim_mem[base + 7][0];
                next_rsp.reprio    = stim_mem[base + 8][0];
                exp_q.push_back(next_rsp);
            end
            @(posedge clk);
        end
        cmd_valid <= 1'b0;

        // Last response first, then the outstanding credits
        while (exp_q.size() != 0)
            @(posedge clk);
        wait_cycles = 0;
        while (free_credits() != CMD_DEPTH && wait_cycles < DRAIN_CYCLES) begin
            @(posedge clk);
            wait_cycles++;
        end
        if (returned_cnt != line_count) begin
            $display("%0d credits came back for %0d commands", returned_cnt, line_count);
            end_with_failure();
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

    initial begin : watchdog
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("Timeout after %0d cycles, the run did not complete", limit_cycles);
        end_with_failure();
    end

endmodule

`default_nettype wire

// ==== sim.f ====
source/mmu_pkg.sv
source/cmd_fifo.sv
source/mmu_control.sv
source/page_map.sv
source/page_status.sv
source/mmu_top.sv
tests/tb_clock.sv
tests/mmu_tb.sv

// ==== tests/mmu_stim.txt ====
// op kind addr data rsp phys used dirty reprio, all hex, addr = page * 400h + offset
// Response columns are zero for commands without a response (rsp = 0)
3 0 00000 000 0 00000 0 0 0
3 0 80000 000 0 00000 0 0 0
3 0 FFC00 003 0 00000 0 0 0
6 0 00000 000 0 00000 0 0 0
4 0 00000 000 1 00000 0 0 1
4 0 80000 000 1 00000 0 0 1
4 0 FFC00 000 1 00000 1 1 1
5 0 80000 000 0 00000 0 0 0
4 0 80000 000 1 00000 0 0 0
4 0 00000 000 1 00000 0 0 1
1 0 01400 123 0 00000 0 0 0
1 0 0A800 3C0 0 00000 0 0 0
1 0 7C000 011 0 00000 0 0 0
3 0 48C00 000 0 00000 0 0 0
3 0 F0000 000 0 00000 0 0 0
3 0 04400 000 0 00000 0 0 0
2 3 016AB 000 1 48EAB 0 0 0
2 B 0A801 000 1 F0001 0 0 0
2 C 7C3FF 000 1 047FF 0 0 0
4 0 48C00 000 1 00000 1 0 1
4 0 F0000 000 1 00000 1 1 1
4 0 04400 000 1 00000 1 1 1
3 0 F0000 001 0 00000 0 0 0
4 0 F0000 000 1 00000 1 0 1
2 2 01410 000 1 48C10 0 0 0
4 0 48C00 000 1 00000 1 1 1
0 0 00000 001 0 00000 0 0 0
2 1 B5155 000 1 B5155 0 0 0
0 0 00000 002 0 00000 0 0 0
2 3 094F0 000 1 48CF0 0 0 0
2 3 F94F0 000 1 48CF0 0 0 0
0 0 00000 000 0 00000 0 0 0
2 4 0ABFE 000 1 F03FE 0 0 0
